//--- common/timer2Pkg.sv
`default_nettype none

package timer2Pkg;

	localparam int dataW = 8;
	localparam int ramAddrW = 12;
	localparam int ioAddrW = 6;

	// Data-space register map
	localparam logic [ramAddrW-1:0] tccrAAddr = 12'h0B0;
	localparam logic [ramAddrW-1:0] tccrBAddr = 12'h0B1;
	localparam logic [ramAddrW-1:0] tcntAddr = 12'h0B2;
	localparam logic [ramAddrW-1:0] ocrAAddr = 12'h0B3;
	localparam logic [ramAddrW-1:0] ocrBAddr = 12'h0B4;
	localparam logic [ramAddrW-1:0] timskAddr = 12'h070;

	// Flag register lives in I/O space
	localparam logic [ioAddrW-1:0] tifrAddr = 6'h17;

	// Interrupt vectors
	localparam logic [ioAddrW-1:0] cmpAVec = 6'h07;
	localparam logic [ioAddrW-1:0] cmpBVec = 6'h08;
	localparam logic [ioAddrW-1:0] ovfVec = 6'h09;

	// Waveform generation modes, {WGM2, WGM1, WGM0}
	localparam logic [2:0] wgmNormal = 3'd0;
	localparam logic [2:0] wgmPcFull = 3'd1;   // Phase correct, TOP = 0xFF
	localparam logic [2:0] wgmCtc = 3'd2;
	localparam logic [2:0] wgmFastFull = 3'd3; // Fast PWM, TOP = 0xFF
	localparam logic [2:0] wgmPcOcr = 3'd5;    // Phase correct, TOP = OCRA
	localparam logic [2:0] wgmFastOcr = 3'd7;  // Fast PWM, TOP = OCRA

	// Writable bits
	localparam logic [dataW-1:0] tccrAMask = 8'hF3;
	localparam logic [dataW-1:0] tccrBMask = 8'h0F; // Force strobes read as zero
	localparam logic [dataW-1:0] timskMask = 8'h07;

	localparam logic [dataW-1:0] bottom = 8'h00;
	localparam logic [dataW-1:0] maxVal = 8'hFF;

	// Shared by flag and mask registers
	localparam int ovfBit = 0;
	localparam int cmpABit = 1;
	localparam int cmpBBit = 2;

endpackage

`default_nettype wire

//--- src/timer2Regs.sv
`timescale 1ns/1ps
`default_nettype none

module timer2Regs import timer2Pkg::*; (
	input  wire logic                cp2,
	input  wire logic                ireset,
	input  wire logic [ramAddrW-1:0] ramAddr,
	input  wire logic                ramWe,
	input  wire logic                ramRe,
	input  wire logic [ioAddrW-1:0]  ioAddr,
	input  wire logic                ioRe,
	input  wire logic [dataW-1:0]    dbusIn,
	input  wire logic                tick,
	input  wire logic [dataW-1:0]    tcnt,
	input  wire logic                atTop,
	input  wire logic                atBottom,
	input  wire logic [dataW-1:0]    tifr,
	output logic      [dataW-1:0]    tccrA,
	output logic      [dataW-1:0]    tccrB,
	output logic      [dataW-1:0]    ocrA,
	output logic      [dataW-1:0]    ocrB,
	output logic      [dataW-1:0]    timsk,
	output logic                     tcntWr,
	output logic      [2:0]          csn,
	output logic      [dataW-1:0]    dbusOut,
	output logic                     outEn
);

	logic [1:0][dataW-1:0] ocrBuf;  // Index 0 is channel A
	logic [1:0][dataW-1:0] ocrAct;
	logic [1:0]            ocrWe;
	logic [1:0]            wgmLow;
	logic                  ocrDirect;
	logic                  ocrSync;

	assign wgmLow = tccrA[1:0];
	assign csn = tccrB[2:0];
	assign tcntWr = ramWe && (ramAddr == tcntAddr);
	assign ocrWe[0] = ramWe && (ramAddr == ocrAAddr);
	assign ocrWe[1] = ramWe && (ramAddr == ocrBAddr);

	// Modes x00/x10 write straight through, PWM modes wait for an update point
	assign ocrDirect = !wgmLow[0];
	assign ocrSync = tick && (((wgmLow == 2'b01) && atTop) || ((wgmLow == 2'b11) && atBottom));

	assign ocrA = ocrAct[0];
	assign ocrB = ocrAct[1];

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tccrA <= '0;
			tccrB <= '0;
			timsk <= '0;
		end else if (ramWe) begin
			if (ramAddr == tccrAAddr) begin
				tccrA <= dbusIn & tccrAMask;
			end
			if (ramAddr == tccrBAddr) begin
				tccrB <= dbusIn & tccrBMask;
			end
			if (ramAddr == timskAddr) begin
				timsk <= dbusIn & timskMask;
			end
		end
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocrBuf <= '0;
			ocrAct <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (ocrWe[i]) begin
					ocrBuf[i] <= dbusIn;  // Buffer always takes the write
				end
				if (ocrDirect && ocrWe[i]) begin
					ocrAct[i] <= dbusIn;
				end else if (ocrSync) begin
					ocrAct[i] <= ocrBuf[i];  // Double-buffered update
				end
			end
		end
	end

	// Read mux, I/O space first
	always_comb begin
		dbusOut = '0;
		outEn = 1'b0;
		if (ioRe && (ioAddr == tifrAddr)) begin
			dbusOut = tifr;
			outEn = 1'b1;
		end else if (ramRe) begin
			outEn = 1'b1;
			case (ramAddr)
				tccrAAddr: dbusOut = tccrA;
				tccrBAddr: dbusOut = tccrB;
				tcntAddr:  dbusOut = tcnt;
				ocrAAddr:  dbusOut = ocrBuf[0];  // Reads see the buffer
				ocrBAddr:  dbusOut = ocrBuf[1];
				timskAddr: dbusOut = timsk;
				default:   outEn = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/timer2Count.sv
`timescale 1ns/1ps
`default_nettype none

module timer2Count import timer2Pkg::*; (
	input  wire logic             cp2,
	input  wire logic             ireset,
	input  wire logic             tick,
	input  wire logic             tcntWr,
	input  wire logic [dataW-1:0] dbusIn,
	input  wire logic [dataW-1:0] tccrA,
	input  wire logic [dataW-1:0] tccrB,
	input  wire logic [dataW-1:0] ocrA,
	output logic      [dataW-1:0] tcnt,
	output logic                  dir,       // High while counting down
	output logic                  atTop,
	output logic                  atBottom,
	output logic                  ovfEv
);

	logic [2:0]       mode;
	logic [dataW-1:0] top;
	logic [dataW-1:0] tcntNext;
	logic             dirNext;

	assign mode = {tccrB[3], tccrA[1:0]};
	assign top = ((mode == wgmCtc) || (mode == wgmPcOcr) || (mode == wgmFastOcr)) ? ocrA : maxVal;
	assign atTop = (tcnt == top);
	assign atBottom = (tcnt == bottom);

	always_comb begin
		tcntNext = tcnt;
		dirNext = 1'b0;
		case (mode)
			wgmNormal, wgmCtc, wgmFastFull, wgmFastOcr: begin
				tcntNext = atTop ? bottom : tcnt + 1'b1;  // Single slope
			end
			wgmPcFull, wgmPcOcr: begin
				dirNext = dir;
				if (!dir) begin
					if (atTop) begin
						tcntNext = top - 1'b1;  // Turn at TOP
						dirNext = 1'b1;
					end else begin
						tcntNext = tcnt + 1'b1;
					end
				end else begin
					if (atBottom) begin
						tcntNext = bottom + 1'b1;
						dirNext = 1'b0;
					end else begin
						tcntNext = tcnt - 1'b1;
					end
				end
			end
			default: ;  // Reserved modes hold
		endcase
	end

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			tcnt <= bottom;
			dir <= 1'b0;
		end else if (tcntWr) begin
			tcnt <= dbusIn;  // Bus write wins over tick
		end else if (tick) begin
			tcnt <= tcntNext;
			dir <= dirNext;
		end
	end

	// Mode 5 shares the low bits of mode 1 and so overflows at bottom
	always_comb begin
		ovfEv = 1'b0;
		if (tick) begin
			if (mode[1:0] == 2'b01) begin
				ovfEv = atBottom && dir;
			end else if (!mode[2]) begin
				ovfEv = (tcnt == maxVal);
			end else if (mode[0]) begin
				ovfEv = atTop;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/timer2Wave.sv
`timescale 1ns/1ps
`default_nettype none

module timer2Wave import timer2Pkg::*; (
	input  wire logic             cp2,
	input  wire logic             ireset,
	input  wire logic             tick,
	input  wire logic [dataW-1:0] tcnt,
	input  wire logic             dir,
	input  wire logic [dataW-1:0] tccrA,
	input  wire logic [dataW-1:0] tccrB,
	input  wire logic [dataW-1:0] ocrA,
	input  wire logic [dataW-1:0] ocrB,
	output logic                  ocA,
	output logic                  ocB,
	output logic                  ocAEn,
	output logic                  ocBEn
);

	logic [2:0] mode;
	logic       nonPwm;
	logic       fastPwm;
	logic       pcPwm;
	logic       atBot;
	logic       matchA;
	logic       matchB;

	assign mode = {tccrB[3], tccrA[1:0]};
	assign nonPwm = (mode == wgmNormal) || (mode == wgmCtc);
	assign fastPwm = (mode == wgmFastFull) || (mode == wgmFastOcr);
	assign pcPwm = (mode == wgmPcFull) || (mode == wgmPcOcr);
	assign atBot = (tcnt == bottom);
	assign matchA = (tcnt == ocrA);
	assign matchB = (tcnt == ocrB);

	// Next pin level for one channel, com is the output mode field
	function automatic logic nextOc(input logic cur, input logic [1:0] com,
			input logic match, input logic pwmToggle);
		logic nxt;
		nxt = cur;
		if (com == 2'b00) begin
			nxt = 1'b0;
		end else if (nonPwm) begin
			if (match) begin
				nxt = (com == 2'b01) ? !cur : com[0];  // 10 clears, 11 sets
			end
		end else if (fastPwm || pcPwm) begin
			if (com == 2'b01) begin
				nxt = pwmToggle ? (match ? !cur : cur) : 1'b0;
			end else if (match) begin
				nxt = pcPwm ? (dir ^ com[0]) : com[0];
			end else if (fastPwm && atBot) begin
				nxt = !com[0];
			end
		end
		return nxt;
	endfunction

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			ocA <= 1'b0;
			ocB <= 1'b0;
		end else if (tick) begin
			ocA <= nextOc(ocA, tccrA[7:6], matchA, mode[2]);  // Toggle only with OCRA as TOP
			ocB <= nextOc(ocB, tccrA[5:4], matchB, 1'b0);
		end
	end

	// Pin enables
	assign ocAEn = tccrA[7] || (tccrA[6] && (tccrB[3] || !tccrA[0]));
	assign ocBEn = tccrA[5] || (tccrA[4] && !tccrB[3] && !tccrA[0]);

endmodule

`default_nettype wire

//--- src/timer2Flags.sv
`timescale 1ns/1ps
`default_nettype none

module timer2Flags import timer2Pkg::*; (
	input  wire logic               cp2,
	input  wire logic               ireset,
	input  wire logic               tick,
	input  wire logic               ovfEv,
	input  wire logic [dataW-1:0]   tcnt,
	input  wire logic [dataW-1:0]   ocrA,
	input  wire logic [dataW-1:0]   ocrB,
	input  wire logic [ioAddrW-1:0] ioAddr,
	input  wire logic               ioWe,
	input  wire logic [dataW-1:0]   dbusIn,
	input  wire logic               irqAck,
	input  wire logic [ioAddrW-1:0] irqAckAddr,
	input  wire logic [dataW-1:0]   timsk,
	output logic      [dataW-1:0]   tifr,
	output logic                    ovfIrq,
	output logic                    cmpAIrq,
	output logic                    cmpBIrq
);

	logic [2:0] flags;
	logic [2:0] flagSet;
	logic [2:0] flagClr;
	logic       tifrWr;

	assign tifrWr = ioWe && (ioAddr == tifrAddr);

	assign flagSet[ovfBit] = ovfEv;
	assign flagSet[cmpABit] = tick && (tcnt == ocrA);  // Compare match A
	assign flagSet[cmpBBit] = tick && (tcnt == ocrB);

	// Vector acknowledge or write-one-to-clear
	assign flagClr[ovfBit] = (irqAck && (irqAckAddr == ovfVec)) || (tifrWr && dbusIn[ovfBit]);
	assign flagClr[cmpABit] = (irqAck && (irqAckAddr == cmpAVec)) || (tifrWr && dbusIn[cmpABit]);
	assign flagClr[cmpBBit] = (irqAck && (irqAckAddr == cmpBVec)) || (tifrWr && dbusIn[cmpBBit]);

	always_ff @(posedge cp2 or negedge ireset) begin
		if (!ireset) begin
			flags <= '0;
		end else begin
			for (int i = 0; i < 3; i++) begin
				if (!flags[i]) begin
					flags[i] <= flagSet[i];
				end else if (flagClr[i]) begin
					flags[i] <= 1'b0;  // Clear tested only once set
				end
			end
		end
	end

	assign tifr = {{(dataW-3){1'b0}}, flags};

	assign ovfIrq = flags[ovfBit] && timsk[ovfBit];
	assign cmpAIrq = flags[cmpABit] && timsk[cmpABit];
	assign cmpBIrq = flags[cmpBBit] && timsk[cmpBBit];

endmodule

`default_nettype wire

//--- src/timer2Top.sv
`timescale 1ns/1ps
`default_nettype none

module timer2Top import timer2Pkg::*; (
	input  wire logic                cp2,
	input  wire logic                ireset,
	input  wire logic [ramAddrW-1:0] ramAddr,
	input  wire logic                ramWe,
	input  wire logic                ramRe,
	input  wire logic [ioAddrW-1:0]  ioAddr,
	input  wire logic                ioWe,
	input  wire logic                ioRe,
	input  wire logic [dataW-1:0]    dbusIn,
	input  wire logic                irqAck,
	input  wire logic [ioAddrW-1:0]  irqAckAddr,
	input  wire logic                tick,        // Prescaler count strobe
	output logic      [dataW-1:0]    dbusOut,
	output logic                     outEn,
	output logic      [2:0]          csn,         // Clock select to prescaler
	output logic                     ocA,
	output logic                     ocB,
	output logic                     ocAEn,
	output logic                     ocBEn,
	output logic                     ovfIrq,
	output logic                     cmpAIrq,
	output logic                     cmpBIrq
);

	logic [dataW-1:0] tccrA;
	logic [dataW-1:0] tccrB;
	logic [dataW-1:0] ocrA;      // Active compare values
	logic [dataW-1:0] ocrB;
	logic [dataW-1:0] timsk;
	logic [dataW-1:0] tifr;
	logic [dataW-1:0] tcnt;
	logic             tcntWr;
	logic             dir;
	logic             atTop;
	logic             atBottom;
	logic             ovfEv;

	timer2Regs uRegs (
		.cp2(cp2), .ireset(ireset),
		.ramAddr(ramAddr), .ramWe(ramWe), .ramRe(ramRe),
		.ioAddr(ioAddr), .ioRe(ioRe), .dbusIn(dbusIn),
		.tick(tick), .tcnt(tcnt), .atTop(atTop), .atBottom(atBottom), .tifr(tifr),
		.tccrA(tccrA), .tccrB(tccrB), .ocrA(ocrA), .ocrB(ocrB), .timsk(timsk),
		.tcntWr(tcntWr), .csn(csn), .dbusOut(dbusOut), .outEn(outEn)
	);

	timer2Count uCount (
		.cp2(cp2), .ireset(ireset), .tick(tick), .tcntWr(tcntWr), .dbusIn(dbusIn),
		.tccrA(tccrA), .tccrB(tccrB), .ocrA(ocrA),
		.tcnt(tcnt), .dir(dir), .atTop(atTop), .atBottom(atBottom), .ovfEv(ovfEv)
	);

	timer2Wave uWave (
		.cp2(cp2), .ireset(ireset), .tick(tick), .tcnt(tcnt), .dir(dir),
		.tccrA(tccrA), .tccrB(tccrB), .ocrA(ocrA), .ocrB(ocrB),
		.ocA(ocA), .ocB(ocB), .ocAEn(ocAEn), .ocBEn(ocBEn)
	);

	timer2Flags uFlags (
		.cp2(cp2), .ireset(ireset), .tick(tick), .ovfEv(ovfEv), .tcnt(tcnt),
		.ocrA(ocrA), .ocrB(ocrB), .ioAddr(ioAddr), .ioWe(ioWe), .dbusIn(dbusIn),
		.irqAck(irqAck), .irqAckAddr(irqAckAddr), .timsk(timsk),
		.tifr(tifr), .ovfIrq(ovfIrq), .cmpAIrq(cmpAIrq), .cmpBIrq(cmpBIrq)
	);

endmodule

`default_nettype wire

//--- bench/timer2_chk.sv
`timescale 1ns/1ps
`default_nettype none

module timer2Chk (
	input wire logic       cp2,
	input wire logic       ireset,
	input wire logic       ramRe,
	input wire logic       ioRe,
	input wire logic       outEn,
	input wire logic [7:0] dbusOut,
	input wire logic       tick,
	input wire logic       ovfIrq,
	input wire logic       cmpAIrq,
	input wire logic       cmpBIrq
);

	// Bus drives only during a read
	outEnRead: assert property (@(posedge cp2) disable iff (!ireset) outEn |-> (ramRe || ioRe))
		else $error("outEn high without a read strobe");

	idleBusZero: assert property (@(posedge cp2) disable iff (!ireset) !outEn |-> dbusOut == 8'h00)
		else $error("dbusOut not zero while outEn is low");

	// Flags only set on a counting edge
	irqAfterTick: assert property (@(posedge cp2) disable iff (!ireset)
			($rose(ovfIrq) || $rose(cmpAIrq) || $rose(cmpBIrq)) |-> $past(tick))
		else $error("interrupt request rose without a preceding tick");

endmodule

bind timer2Top timer2Chk chkI (
	.cp2(cp2), .ireset(ireset), .ramRe(ramRe), .ioRe(ioRe), .outEn(outEn),
	.dbusOut(dbusOut), .tick(tick), .ovfIrq(ovfIrq), .cmpAIrq(cmpAIrq), .cmpBIrq(cmpBIrq)
);

`default_nettype wire

//--- bench/timer2Tb.sv
`timescale 1ns/1ps
`default_nettype none

module timer2Tb;
	import timer2Pkg::*;

	logic                cp2;
	logic                ireset;
	logic [ramAddrW-1:0] ramAddr;
	logic                ramWe;
	logic                ramRe;
	logic [ioAddrW-1:0]  ioAddr;
	logic                ioWe;
	logic                ioRe;
	logic [dataW-1:0]    dbusIn;
	logic                irqAck;
	logic [ioAddrW-1:0]  irqAckAddr;
	logic                tick;
	logic [dataW-1:0]    dbusOut;
	logic                outEn;
	logic [2:0]          csn;
	logic                ocA, ocB, ocAEn, ocBEn;
	logic                ovfIrq, cmpAIrq, cmpBIrq;

	logic [31:0] lfsr = 32'h824c;
	int          valueErrs = 0;
	int          readErrs = 0;

	// Model state
	logic [7:0] mTccrA, mTccrB, mTimsk, mCnt, mBufA, mBufB, mOcrA, mOcrB;
	logic [2:0] mFlags;
	logic       mDir, mOcA, mOcB;

	timer2Top dut_i (.*);

	initial begin
		cp2 = 1'b0;
		forever #50 cp2 = ~cp2;
	end

	// Watchdog, twice the test budget of about 3000 cycles
	initial begin
		#(6000 * 100);
		$display("Timeout: the run did not finish within its cycle budget");
		$display("TB FAILED");
		$finish;
	end

	function automatic logic [7:0] randBits(input int n);
		logic [7:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			r = {r[6:0], lfsr[0]};
		end
		return r;
	endfunction

	function automatic logic [7:0] pickCmp();
		logic [7:0] v;
		v = randBits(8);
		if (v == 8'h00 || v == 8'hFF) v = 8'h80;  // Keep matches off the turn points
		return v;
	endfunction

	// Next count and direction from the counter rules
	function automatic logic [8:0] refCount(input logic [7:0] cnt, input logic down,
			input logic [2:0] mode, input logic [7:0] top);
		case (mode)
			3'd0, 3'd2, 3'd3, 3'd7: return {1'b0, (cnt == top) ? 8'h00 : cnt + 8'd1};
			3'd1, 3'd5: begin
				if (!down) return (cnt == top) ? {1'b1, top - 8'd1} : {1'b0, cnt + 8'd1};
				else return (cnt == 8'h00) ? {1'b0, 8'h01} : {1'b1, cnt - 8'd1};
			end
			default: return {down, cnt};
		endcase
	endfunction

	// Next compare pin level from the output mode rules
	function automatic logic refOc(input logic cur, input logic [1:0] com, input logic match,
			input logic [2:0] mode, input logic down, input logic atZero, input logic chanA);
		if (com == 2'b00) return 1'b0;
		case (mode)
			3'd0, 3'd2: if (match) return (com == 2'b01) ? !cur : com[0];
			3'd3, 3'd7, 3'd1, 3'd5: begin
				if (com == 2'b01) begin
					if (!(chanA && mode[2])) return 1'b0;
					return match ? !cur : cur;
				end
				if (match) return (mode[1] ? 1'b0 : down) ^ com[0];
				if (mode[1] && atZero) return !com[0];  // Fast PWM sets at bottom
			end
			default: ;
		endcase
		return cur;
	endfunction

	// Pin drives whenever its output mode can move it
	function automatic logic refPinEn(input logic [1:0] com, input logic [2:0] mode,
			input logic chanA);
		if (com[1]) return 1'b1;
		if (!com[0]) return 1'b0;
		return (mode == 3'd0 || mode == 3'd2 || (chanA && (mode == 3'd5 || mode == 3'd7)));
	endfunction

	always @(posedge cp2 or negedge ireset) begin
		logic [2:0] mode;
		logic [7:0] top;
		logic [8:0] nxt;
		logic [2:0] setEv, clrEv;
		logic       nOcA, nOcB, sync, wr;
		if (!ireset) begin
			{mTccrA, mTccrB, mTimsk, mCnt, mBufA, mBufB, mOcrA, mOcrB} = '0;
			{mFlags, mDir, mOcA, mOcB} = '0;
		end else begin
			mode = {mTccrB[3], mTccrA[1:0]};
			top = (mode == 3'd2 || mode == 3'd5 || mode == 3'd7) ? mOcrA : 8'hFF;
			nxt = refCount(mCnt, mDir, mode, top);
			setEv[0] = tick && ((mode == 3'd0 || mode == 3'd2 || mode == 3'd3) ? mCnt == 8'hFF :
				(mode == 3'd1 || mode == 3'd5) ? (mCnt == 8'h00 && mDir) :
				(mode == 3'd7) && (mCnt == top));
			setEv[1] = tick && (mCnt == mOcrA);
			setEv[2] = tick && (mCnt == mOcrB);
			clrEv[0] = (irqAck && irqAckAddr == 6'h09) || (ioWe && ioAddr == 6'h17 && dbusIn[0]);
			clrEv[1] = (irqAck && irqAckAddr == 6'h07) || (ioWe && ioAddr == 6'h17 && dbusIn[1]);
			clrEv[2] = (irqAck && irqAckAddr == 6'h08) || (ioWe && ioAddr == 6'h17 && dbusIn[2]);
			nOcA = refOc(mOcA, mTccrA[7:6], mCnt == mOcrA, mode, mDir, mCnt == 8'h00, 1'b1);
			nOcB = refOc(mOcB, mTccrA[5:4], mCnt == mOcrB, mode, mDir, mCnt == 8'h00, 1'b0);
			sync = tick && ((mTccrA[1:0] == 2'b01 && mCnt == top) ||
				(mTccrA[1:0] == 2'b11 && mCnt == 8'h00));
			if (tick) begin
				mOcA = nOcA;
				mOcB = nOcB;
			end
			for (int i = 0; i < 3; i++) begin
				if (!mFlags[i]) mFlags[i] = setEv[i];
				else if (clrEv[i]) mFlags[i] = 1'b0;
			end
			if (ramWe && ramAddr == 12'h0B2) begin
				mCnt = dbusIn;
			end else if (tick) begin
				{mDir, mCnt} = nxt;
			end
			if (sync) begin
				mOcrA = mBufA;
				mOcrB = mBufB;
			end
			wr = ramWe && !mTccrA[0];  // Modes x00 and x10 write straight through
			if (ramWe && ramAddr == 12'h0B3) mBufA = dbusIn;
			if (ramWe && ramAddr == 12'h0B4) mBufB = dbusIn;
			if (wr && ramAddr == 12'h0B3) mOcrA = dbusIn;
			if (wr && ramAddr == 12'h0B4) mOcrB = dbusIn;
			if (ramWe && ramAddr == 12'h0B0) mTccrA = dbusIn & 8'hF3;
			if (ramWe && ramAddr == 12'h0B1) mTccrB = dbusIn & 8'h0F;
			if (ramWe && ramAddr == 12'h070) mTimsk = dbusIn & 8'h07;
		end
	end

	task automatic reportMismatch(input string msg);
		valueErrs++;
		$display("Fail at %0t: %s", $time, msg);
	endtask

	// Compare process, outputs are stable at the falling edge
	always @(negedge cp2) begin
		logic [7:0] expOut;
		logic       expEn;
		logic [2:0] mode;
		if (ireset) begin
			mode = {mTccrB[3], mTccrA[1:0]};
			expEn = 1'b1;
			expOut = 8'h00;
			if (ioRe && ioAddr == 6'h17) expOut = {5'b0, mFlags};
			else if (!ramRe) expEn = 1'b0;
			else begin
				case (ramAddr)
					12'h0B0: expOut = mTccrA;
					12'h0B1: expOut = mTccrB;
					12'h0B2: expOut = mCnt;
					12'h0B3: expOut = mBufA;
					12'h0B4: expOut = mBufB;
					12'h070: expOut = mTimsk;
					default: expEn = 1'b0;
				endcase
			end
			if (outEn !== expEn || dbusOut !== expOut)
				reportMismatch($sformatf("read data %h/%b, expected %h/%b", dbusOut, outEn,
					expOut, expEn));
			if (dut_i.tcnt !== mCnt)
				reportMismatch($sformatf("count %h, expected %h", dut_i.tcnt, mCnt));
			if (ocA !== mOcA) reportMismatch($sformatf("ocA %b, expected %b", ocA, mOcA));
			if (ocB !== mOcB) reportMismatch($sformatf("ocB %b, expected %b", ocB, mOcB));
			if ({cmpBIrq, cmpAIrq, ovfIrq} !== (mFlags & mTimsk[2:0]))
				reportMismatch($sformatf("requests %b, expected %b",
					{cmpBIrq, cmpAIrq, ovfIrq}, mFlags & mTimsk[2:0]));
			if (csn !== mTccrB[2:0]) reportMismatch("clock select differs");
			// Reserved modes leave the channel A toggle enable open
			if (!(mode[2] && !mode[0]) && ocAEn !== refPinEn(mTccrA[7:6], mode, 1'b1))
				reportMismatch("ocA pin enable wrong");
			if (ocBEn !== refPinEn(mTccrA[5:4], mode, 1'b0))
				reportMismatch("ocB pin enable wrong");
		end
	end

	task automatic runCycles(input int n);
		repeat (n) begin
			@(posedge cp2);
			tick <= (randBits(2) != 2'b00);
		end
	endtask

	task automatic writeReg(input logic [11:0] addr, input logic [7:0] data);
		@(posedge cp2);
		ramAddr <= addr;
		ramWe <= 1'b1;
		dbusIn <= data;
		tick <= 1'b0;
		@(posedge cp2);
		ramWe <= 1'b0;
	endtask

	task automatic readCheck(input logic [11:0] addr, input logic [7:0] exp);
		@(posedge cp2);
		ramAddr <= addr;
		ramRe <= 1'b1;
		tick <= 1'b0;
		@(negedge cp2);
		if (outEn !== 1'b1 || dbusOut !== exp) begin
			readErrs++;
			$display("Fail at %0t: read %h from %h, expected %h", $time, dbusOut, addr, exp);
		end
		@(posedge cp2);
		ramRe <= 1'b0;
	endtask

	task automatic ackVector(input logic [5:0] vec);
		@(posedge cp2);
		irqAck <= 1'b1;
		irqAckAddr <= vec;
		tick <= 1'b0;
		@(posedge cp2);
		irqAck <= 1'b0;
	endtask

	task automatic writeFlags(input logic [7:0] data);
		@(posedge cp2);
		ioAddr <= tifrAddr;
		ioWe <= 1'b1;
		dbusIn <= data;
		tick <= 1'b0;
		@(posedge cp2);
		ioWe <= 1'b0;
	endtask

	task automatic readFlags();
		@(posedge cp2);
		ioAddr <= tifrAddr;
		ioRe <= 1'b1;
		ramAddr <= tcntAddr;  // I/O read must win over a mapped data read
		ramRe <= 1'b1;
		tick <= 1'b0;
		@(posedge cp2);
		ioRe <= 1'b0;
		ramRe <= 1'b0;
	endtask

	task automatic unmappedRead();
		@(posedge cp2);
		ramAddr <= 12'h0B5;
		ramRe <= 1'b1;
		ioAddr <= 6'h16;
		ioRe <= 1'b1;
		@(posedge cp2);
		ramRe <= 1'b0;
		ioRe <= 1'b0;
	endtask

	initial begin
		logic [11:0] addrs[6];
		logic [7:0]  masks[6];
		logic [7:0]  d;
		addrs = '{12'h0B0, 12'h0B1, 12'h0B2, 12'h0B3, 12'h0B4, 12'h070};
		masks = '{8'hF3, 8'h0F, 8'hFF, 8'hFF, 8'hFF, 8'h07};
		ireset = 1'b0;
		{ramAddr, ramWe, ramRe, ioAddr, ioWe, ioRe} = '0;
		{dbusIn, irqAck, irqAckAddr, tick} = '0;
		repeat (2) @(posedge cp2);
		ireset <= 1'b1;
		// Register access
		for (int i = 0; i < 6; i++) begin
			d = randBits(8);
			writeReg(addrs[i], d);
			readCheck(addrs[i], d & masks[i]);
		end
		unmappedRead();
		writeReg(tccrAAddr, 8'h00);
		writeReg(tccrBAddr, 8'h00);
		writeReg(timskAddr, 8'h07);
		// Normal mode overflow
		writeReg(tcntAddr, 8'hF0);
		runCycles(60);
		readFlags();
		ackVector(ovfVec);
		writeReg(tcntAddr, 8'hF0);
		runCycles(60);
		writeFlags(8'h01);
		// CTC with toggling ocA
		writeReg(ocrAAddr, 8'h10 + randBits(5));
		writeReg(tccrAAddr, 8'h42);
		writeReg(tcntAddr, 8'h00);
		runCycles(200);
		ackVector(cmpAVec);
		runCycles(100);
		writeFlags(8'h02);
		// Fast PWM, non-inverting then inverting
		writeReg(tccrAAddr, 8'hA3);
		d = pickCmp();
		writeReg(ocrAAddr, d);
		readCheck(ocrAAddr, d);
		writeReg(ocrBAddr, pickCmp());
		runCycles(400);
		writeReg(tccrAAddr, 8'hF3);
		writeReg(ocrAAddr, pickCmp());
		writeReg(ocrBAddr, pickCmp());
		runCycles(400);
		// Phase correct with ocB
		writeReg(tccrAAddr, 8'h21);
		writeReg(ocrBAddr, pickCmp());
		writeReg(tcntAddr, 8'h00);
		runCycles(500);
		ackVector(cmpBVec);
		runCycles(600);
		$display("Errors: %0d value mismatches, %0d read-back mismatches", valueErrs, readErrs);
		if (valueErrs == 0 && readErrs == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- timer2.f
common/timer2Pkg.sv
src/timer2Regs.sv
src/timer2Count.sv
src/timer2Wave.sv
src/timer2Flags.sv
src/timer2Top.sv
bench/timer2_chk.sv
bench/timer2Tb.sv

//--- Bender.yml
package:
  name: timer2

sources:
  - files:
      - common/timer2Pkg.sv
      - src/timer2Regs.sv
      - src/timer2Count.sv
      - src/timer2Wave.sv
      - src/timer2Flags.sv
      - src/timer2Top.sv
  - target: test
    files:
      - bench/timer2_chk.sv
      - bench/timer2Tb.sv
